// File: source/fetch_pkg.sv
package fetch_pkg;

    // Address and word widths
    localparam int FETCH_ADDR_W = 16;
    localparam int INSTR_W      = 32;

    // Fetch cache entries
    localparam int FC_DEPTH = 4;

    // Fetch queue pointer width, one slot always stays empty
    localparam int FQ_ADDR_W = 3;
    localparam int FQ_DEPTH  = 2 ** FQ_ADDR_W;

    // Byte distance between consecutive instructions
    localparam logic [FETCH_ADDR_W-1:0] PC_STEP = FETCH_ADDR_W'(4);

    typedef enum logic [0:0] {
        ST_LOOKUP    = 1'b0,
        ST_MISS_WAIT = 1'b1
    } fetch_state_e;

    // Queue entry
    typedef struct packed {
        logic [FETCH_ADDR_W-1:0] pc;
        logic [INSTR_W-1:0]      instr;
    } fetch_entry_t;

    // Memory reply, valid is a one-cycle strobe
    typedef struct packed {
        logic               valid;
        logic [INSTR_W-1:0] data;
    } mem_rsp_t;

    // Cache write port
    typedef struct packed {
        logic                    en;
        logic [FETCH_ADDR_W-1:0] key;
        logic [INSTR_W-1:0]      data;
    } cache_push_t;

endpackage

// File: source/fetch_sequencer.sv
`timescale 1ns/1ns

module fetch_sequencer (
    input  logic                                i_redirect,
    input  logic [fetch_pkg::FETCH_ADDR_W-1:0]  i_redirect_pc,

    output logic [fetch_pkg::FETCH_ADDR_W-1:0]  o_find_key,
    input  logic                                i_hit,
    input  logic [fetch_pkg::INSTR_W-1:0]       i_hit_data,

    output fetch_pkg::cache_push_t              o_push,

    output logic                                o_mem_req,
    output logic [fetch_pkg::FETCH_ADDR_W-1:0]  o_mem_addr,
    input  fetch_pkg::mem_rsp_t                 i_mem_rsp,

    output logic                                o_wr,
    output fetch_pkg::fetch_entry_t             o_wr_entry,
    input  logic                                i_full,

    input  logic                                clk,
    input  logic                                rstn
);

    fetch_pkg::fetch_state_e state;

    logic [fetch_pkg::FETCH_ADDR_W-1:0] pc;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] miss_addr;

    // Lookup result may be used this cycle
    logic lookup_ok;
    logic lookup_miss;
    logic rsp_seen;

    assign lookup_ok   = (state == fetch_pkg::ST_LOOKUP) && !i_full && !i_redirect;
    assign lookup_miss = lookup_ok && !i_hit;
    assign rsp_seen    = (state == fetch_pkg::ST_MISS_WAIT) && i_mem_rsp.valid;

    assign o_find_key = pc;

    // Hits go straight into the queue
    assign o_wr             = lookup_ok && i_hit;
    assign o_wr_entry.pc    = pc;
    assign o_wr_entry.instr = i_hit_data;

    // Reply is filed under the address that missed, even after a redirect
    assign o_push.en   = rsp_seen;
    assign o_push.key  = miss_addr;
    assign o_push.data = i_mem_rsp.data;

    assign o_mem_addr = miss_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= fetch_pkg::ST_LOOKUP;
            pc        <= '0;
            o_mem_req <= 1'b0;
        end else begin
            o_mem_req <= 1'b0;

            if (i_redirect) begin
                pc <= i_redirect_pc;
            end

            case (state)
                fetch_pkg::ST_LOOKUP: begin
                    if (lookup_ok) begin
                        if (i_hit) begin
                            pc <= pc + fetch_pkg::PC_STEP;
                        end else begin
                            // Single outstanding request
                            state     <= fetch_pkg::ST_MISS_WAIT;
                            o_mem_req <= 1'b1;
                        end
                    end
                end

                fetch_pkg::ST_MISS_WAIT: begin
                    // Next lookup at pc hits, unless pc was redirected
                    if (i_mem_rsp.valid) begin
                        state <= fetch_pkg::ST_LOOKUP;
                    end
                end

                default: begin
                    state <= fetch_pkg::ST_LOOKUP;
                end
            endcase
        end
    end

    // Address held stable until the reply
    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            miss_addr <= pc;
        end
    end

endmodule

// File: source/fetch_cache.sv
`timescale 1ns/1ns

module fetch_cache (
    input  fetch_pkg::cache_push_t              i_push,

    input  logic [fetch_pkg::FETCH_ADDR_W-1:0]  i_find_key,
    output logic                                o_hit,
    output logic [fetch_pkg::INSTR_W-1:0]       o_hit_data,

    input  logic                                i_clear,

    input  logic                                clk,
    input  logic                                rstn
);

    logic [fetch_pkg::FC_DEPTH-1:0]     valid;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] keys [fetch_pkg::FC_DEPTH];
    logic [fetch_pkg::INSTR_W-1:0]      data [fetch_pkg::FC_DEPTH];

    // Row i bit j set means entry i was pushed after entry j
    logic [fetch_pkg::FC_DEPTH-1:0] age [fetch_pkg::FC_DEPTH];

    logic [fetch_pkg::FC_DEPTH-1:0] key_match;
    logic [fetch_pkg::FC_DEPTH-1:0] free_sel;
    logic [fetch_pkg::FC_DEPTH-1:0] oldest_sel;
    logic [fetch_pkg::FC_DEPTH-1:0] place;

    // Candidate places for a push
    always_comb begin
        logic free_found;
        logic old_found;

        free_found = 1'b0;
        old_found  = 1'b0;
        key_match  = '0;
        free_sel   = '0;
        oldest_sel = '0;

        for (int i = 0; i < fetch_pkg::FC_DEPTH; i++) begin
            key_match[i] = valid[i] && (keys[i] == i_push.key);

            if (!valid[i] && !free_found) begin
                free_sel[i] = 1'b1;
                free_found  = 1'b1;
            end

            // Only consulted when every entry is valid
            if ((age[i] == '0) && !old_found) begin
                oldest_sel[i] = 1'b1;
                old_found     = 1'b1;
            end
        end
    end

    always_comb begin
        if (!i_push.en) begin
            place = '0;
        end else if (|key_match) begin
            place = key_match;
        end else if (|free_sel) begin
            place = free_sel;
        end else begin
            place = oldest_sel;
        end
    end

    // Single find port, valid entries only
    always_comb begin
        o_hit      = 1'b0;
        o_hit_data = '0;
        for (int i = 0; i < fetch_pkg::FC_DEPTH; i++) begin
            if (valid[i] && (keys[i] == i_find_key)) begin
                o_hit      = 1'b1;
                o_hit_data = data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            for (int i = 0; i < fetch_pkg::FC_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            // Clear beats a push in the same cycle
            if (i_clear) begin
                valid <= '0;
            end else begin
                valid <= valid | place;
            end

            if (i_push.en) begin
                for (int i = 0; i < fetch_pkg::FC_DEPTH; i++) begin
                    if (place[i]) begin
                        age[i] <= ~place;
                    end else begin
                        age[i] <= age[i] & ~place;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_pkg::FC_DEPTH; i++) begin
            if (place[i]) begin
                keys[i] <= i_push.key;
                data[i] <= i_push.data;
            end
        end
    end

endmodule

// File: source/fetch_ring_buf.sv
`timescale 1ns/1ns

module fetch_ring_buf (
    input  logic                     i_wr,
    input  fetch_pkg::fetch_entry_t  i_wr_entry,
    output logic                     o_full,

    input  logic                     i_deq,
    output logic                     o_valid,
    output fetch_pkg::fetch_entry_t  o_entry,

    input  logic                     i_flush,

    input  logic                     clk,
    input  logic                     rstn
);

    fetch_pkg::fetch_entry_t mem [fetch_pkg::FQ_DEPTH];

    // Next slot to write and next slot to read
    logic [fetch_pkg::FQ_ADDR_W-1:0] wr_ptr;
    logic [fetch_pkg::FQ_ADDR_W-1:0] rd_ptr;
    logic [fetch_pkg::FQ_ADDR_W-1:0] wr_ptr_nxt;

    logic empty;
    logic do_wr;
    logic do_rd;
    logic bypass;

    assign wr_ptr_nxt = wr_ptr + 1'b1;
    assign empty      = (wr_ptr == rd_ptr);
    assign o_full     = (wr_ptr_nxt == rd_ptr);

    // The sequencer only writes while o_full is low
    assign do_wr  = i_wr && !i_flush;
    assign do_rd  = i_deq && !i_flush && (!empty || i_wr);
    assign bypass = empty && i_wr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_valid <= 1'b0;
        end else if (i_flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_entry;
        end
    end

    // Output register, fed straight from the write port when empty
    always_ff @(posedge clk) begin
        if (do_rd) begin
            if (bypass) begin
                o_entry <= i_wr_entry;
            end else begin
                o_entry <= mem[rd_ptr];
            end
        end
    end

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                                i_redirect,
    input  logic [fetch_pkg::FETCH_ADDR_W-1:0]  i_redirect_pc,
    input  logic                                i_invalidate,

    output logic                                o_mem_req,
    output logic [fetch_pkg::FETCH_ADDR_W-1:0]  o_mem_addr,
    input  fetch_pkg::mem_rsp_t                 i_mem_rsp,

    input  logic                                i_deq,
    output logic                                o_valid,
    output fetch_pkg::fetch_entry_t             o_entry,

    input  logic                                clk,
    input  logic                                rstn
);

    logic [fetch_pkg::FETCH_ADDR_W-1:0] find_key;
    logic                               hit;
    logic [fetch_pkg::INSTR_W-1:0]      hit_data;
    fetch_pkg::cache_push_t             push;

    logic                               wr;
    fetch_pkg::fetch_entry_t            wr_entry;
    logic                               full;

    fetch_sequencer seq_i (
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_find_key    (find_key),
        .i_hit         (hit),
        .i_hit_data    (hit_data),
        .o_push        (push),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_rsp     (i_mem_rsp),
        .o_wr          (wr),
        .o_wr_entry    (wr_entry),
        .i_full        (full),
        .clk           (clk),
        .rstn          (rstn)
    );

    fetch_cache cache_i (
        .i_push     (push),
        .i_find_key (find_key),
        .o_hit      (hit),
        .o_hit_data (hit_data),
        .i_clear    (i_invalidate),
        .clk        (clk),
        .rstn       (rstn)
    );

    // Redirect also flushes the queue
    fetch_ring_buf queue_i (
        .i_wr       (wr),
        .i_wr_entry (wr_entry),
        .o_full     (full),
        .i_deq      (i_deq),
        .o_valid    (o_valid),
        .o_entry    (o_entry),
        .i_flush    (i_redirect),
        .clk        (clk),
        .rstn       (rstn)
    );

endmodule

// File: tests/fetch_sva.sv
`timescale 1ns/1ns

module fetch_sva (
    input logic                clk,
    input logic                rstn,
    input logic                i_mem_req,
    input fetch_pkg::mem_rsp_t i_mem_rsp,
    input logic                i_deq,
    input logic                i_valid
);

    // High from a request until its reply
    logic outstanding;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            outstanding <= 1'b0;
        end else if (i_mem_req) begin
            outstanding <= 1'b1;
        end else if (i_mem_rsp.valid) begin
            outstanding <= 1'b0;
        end
    end

    single_request: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_req |-> !outstanding)
        else $error("memory request issued while another one is outstanding");

    valid_after_deq: assert property (@(posedge clk) disable iff (!rstn)
        i_valid |-> $past(i_deq))
        else $error("o_valid without a dequeue in the previous cycle");

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> (!i_mem_req && !i_valid))
        else $error("o_mem_req or o_valid high during reset");

endmodule

bind fetch_top fetch_sva sva_i (
    .clk       (clk),
    .rstn      (rstn),
    .i_mem_req (o_mem_req),
    .i_mem_rsp (i_mem_rsp),
    .i_deq     (i_deq),
    .i_valid   (o_valid)
);

// File: tests/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    localparam int TIMEOUT_CYCLES = 300;

    logic clk = 1'b0;
    logic rstn;

    logic                               i_redirect;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] i_redirect_pc;
    logic                               i_invalidate;
    logic                               o_mem_req;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] o_mem_addr;
    fetch_pkg::mem_rsp_t                i_mem_rsp = '0;
    logic                               i_deq;
    logic                               o_valid;
    fetch_pkg::fetch_entry_t            o_entry;

    // Memory responder
    integer                             seed = 32'hb475_3b6a;
    int                                 rsp_delay = 0;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] rsp_addr;
    logic [fetch_pkg::FETCH_ADDR_W-1:0] req_log [$];

    logic [fetch_pkg::FETCH_ADDR_W-1:0] exp_pc = '0;
    int                                 valid_count = 0;
    int                                 error_count = 0;
    int                                 req_base;
    int                                 valid_base;

    fetch_top dut_i (
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_invalidate  (i_invalidate),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_rsp     (i_mem_rsp),
        .i_deq         (i_deq),
        .o_valid       (o_valid),
        .o_entry       (o_entry),
        .clk           (clk),
        .rstn          (rstn)
    );

    always #50 clk = ~clk;

    // Instruction memory contents
    function automatic logic [fetch_pkg::INSTR_W-1:0] mem_word(
        input logic [fetch_pkg::FETCH_ADDR_W-1:0] addr
    );
        return {addr[7:0] ^ 8'h5c, addr[15:8] ^ 8'ha1, ~addr ^ {addr[3:0], addr[15:4]}};
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        error_count++;
        $display("[FAIL] %s = %h, expected %h", name, got, exp);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Last dequeued entry gets checked before the stream changes
    task automatic stop_deq();
        i_deq = 1'b0;
        idle(2);
    endtask

    task automatic redirect_to(input logic [fetch_pkg::FETCH_ADDR_W-1:0] pc);
        i_redirect    = 1'b1;
        i_redirect_pc = pc;
        exp_pc        = pc;
        @(negedge clk);
        i_redirect    = 1'b0;
    endtask

    task automatic wait_valid_count(input int target);
        int cycles = 0;
        while (valid_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_error("timeout while waiting for dequeued entries");
            end
        end
    endtask

    task automatic wait_req_count(input int target);
        int cycles = 0;
        while (req_log.size() < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_error("timeout while waiting for memory requests");
            end
        end
    endtask

    task automatic wait_req_addr(input logic [fetch_pkg::FETCH_ADDR_W-1:0] addr,
                                 input int from);
        int cycles = 0;
        bit found  = 1'b0;
        while (!found) begin
            for (int i = from; i < req_log.size(); i++) begin
                if (req_log[i] == addr) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT_CYCLES) begin
                    report_error("timeout while waiting for a request to a given address");
                end
            end
        end
    endtask

    // Request side, sampled before the edge updates the DUT
    always @(posedge clk) begin
        if (rstn && o_mem_req) begin
            req_log.push_back(o_mem_addr);
            rsp_addr  = o_mem_addr;
            rsp_delay = 1 + ($unsigned($random(seed)) % 4);
        end
    end

    // Reply strobe, one cycle wide
    always @(negedge clk) begin
        i_mem_rsp.valid = 1'b0;
        if (rsp_delay != 0) begin
            rsp_delay = rsp_delay - 1;
            if (rsp_delay == 0) begin
                i_mem_rsp.valid = 1'b1;
                i_mem_rsp.data  = mem_word(rsp_addr);
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && o_valid) begin
            assert (o_entry.pc == exp_pc)
                else report_value("o_entry.pc", o_entry.pc, exp_pc);
            assert (o_entry.instr == mem_word(exp_pc))
                else report_value("o_entry.instr", o_entry.instr, mem_word(exp_pc));
            exp_pc = exp_pc + 16'd4;
            valid_count++;
        end
    end

    initial begin
        rstn          = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_invalidate  = 1'b0;
        i_deq         = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        // Continuous stream from reset
        i_deq = 1'b1;
        wait_valid_count(8);

        // Seven entries fill the queue and requests stop
        stop_deq();
        redirect_to(16'h0100);
        req_base   = req_log.size();
        valid_base = valid_count;
        wait_req_count(req_base + 7);
        idle(20);
        assert (req_log.size() == req_base + 7)
            else report_error("memory request issued while the fetch queue was full");
        i_deq = 1'b1;
        wait_valid_count(valid_base + 9);

        // Fill wrapping past zero leaves 0..12 in the cache
        stop_deq();
        redirect_to(16'hfff4);
        req_base = req_log.size();
        wait_req_count(req_base + 7);
        idle(20);
        assert (req_log.size() == req_base + 7)
            else report_error("memory request issued while the fetch queue was full");

        // Redirect with a full queue, cached words come back without requests
        redirect_to(16'h0000);
        req_base   = req_log.size();
        valid_base = valid_count;
        i_deq      = 1'b1;
        wait_req_addr(16'h0010, req_base);
        wait_valid_count(valid_base + 5);
        for (int i = req_base; i < req_log.size(); i++) begin
            assert (req_log[i] >= 16'h0010)
                else report_error($sformatf("[FAIL] o_mem_addr = %h requested while cached",
                                            req_log[i]));
        end

        // Invalidate, then dequeue on the queue that the redirect emptied
        stop_deq();
        i_invalidate = 1'b1;
        @(negedge clk);
        i_invalidate = 1'b0;
        valid_base   = valid_count;
        i_deq        = 1'b1;
        // Address 0x10 is still cached and misses only after the invalidate
        redirect_to(16'h0010);
        req_base = req_log.size();
        idle(2);
        i_deq = 1'b0;
        idle(2);
        assert (valid_count == valid_base)
            else report_error("o_valid pulsed for a dequeue on an empty queue");
        wait_req_addr(16'h0010, req_base);
        i_deq = 1'b1;
        wait_valid_count(valid_base + 2);
        stop_deq();

        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/fetch_pkg.sv
source/fetch_sequencer.sv
source/fetch_cache.sv
source/fetch_ring_buf.sv
source/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_tb.sv
